// File: credit_sync_pkg.sv
`default_nettype none

package credit_sync_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // payload width of one link word
  localparam int DATA_WIDTH = 16;

  // every credit count (available, owed, shadow) shares this width
  localparam int CREDIT_WIDTH = 4;

  //////////////////////////////
  // vector types
  //////////////////////////////

  // one payload word as it travels toward the link
  typedef logic [DATA_WIDTH-1:0] data_t;

  // any count of credits, either spendable or owed back to the far side
  typedef logic [CREDIT_WIDTH-1:0] credit_t;

  //////////////////////////////
  // credit constants
  //////////////////////////////

  // depth of the far-side receive buffer, so the available counter starts here
  localparam credit_t NUM_CREDITS = credit_t'(8);

  // once this many credits are owed, a credits-only packet may be forced out
  localparam credit_t FORCE_SEND_THRESH = credit_t'(4);

  // cost of an accepted data packet, every packet takes one buffer entry
  localparam credit_t DATA_PKT_COST = credit_t'(1);

  // cost of an accepted credits-only packet
  localparam credit_t CRED_ONLY_COST = credit_t'(1);

  // the stage either forwards source data or emits credits-only packets
  typedef enum logic [0:0] {
    MODE_NORMAL       = 1'b0,
    MODE_CREDITS_ONLY = 1'b1
  } pkt_mode_e;

endpackage

`default_nettype wire

// File: credit_return_tracker.sv
`timescale 1ns/1ps
`default_nettype none

// counts entries freed by the local receive buffer, which are the credits
// owed back to the far side
module credit_return_tracker (
  input  wire logic                     clk_i,
  input  wire logic                     reset_i,
  // handshake on the local buffer output, one freed entry per cycle
  input  wire logic                     buffer_out_valid_i,
  input  wire logic                     buffer_out_ready_i,
  // link handshake pulses resolved by the output side
  input  wire logic                     out_fire_i,
  input  wire logic                     out_stall_i,
  output      credit_sync_pkg::credit_t credits_owed_o,
  output      logic                     force_send_o
);

  import credit_sync_pkg::*;

  // one buffer entry is released when both sides of the buffer handshake agree
  logic    entry_freed;
  credit_t freed_inc;

  // the visible count is what goes out with the next packet
  credit_t owed_q;
  // the shadow collects releases while an outgoing packet waits on the link,
  // so the count offered under a pending valid never moves
  credit_t shadow_q;

  assign entry_freed = buffer_out_valid_i & buffer_out_ready_i;
  assign freed_inc   = {{(CREDIT_WIDTH-1){1'b0}}, entry_freed};

  //////////////////////////////
  // owed counters
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owed_q   <= '0;
      shadow_q <= '0;
    end else if (out_fire_i) begin
      // the visible count has just been handed to the link, so it restarts
      // from whatever piled up in the shadow plus a release in this cycle
      owed_q   <= shadow_q + freed_inc;
      shadow_q <= '0;
    end else if (out_stall_i) begin
      // valid is up but the link holds us off, keep the offered count frozen
      shadow_q <= shadow_q + freed_inc;
    end else begin
      // no packet pending, releases show directly on the visible count
      owed_q <= owed_q + freed_inc;
    end
  end

  //////////////////////////////
  // force-send flag
  //////////////////////////////

  // too many credits owed means the far side could run dry, ask the
  // controller to push a credits-only packet if no data is around
  assign force_send_o = (owed_q >= FORCE_SEND_THRESH);

  assign credits_owed_o = owed_q;

endmodule

`default_nettype wire

// File: credit_flow_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// keeps the credits we may still spend toward the far side and decides which
// kind of packet the stage offers next
module credit_flow_ctrl (
  input  wire logic                       clk_i,
  input  wire logic                       reset_i,
  // credits handed back by the far side, qualified by a one-cycle strobe
  input  wire credit_sync_pkg::credit_t   credits_received_i,
  input  wire logic                       receive_cred_i,
  // source valid, needed to decide whether forcing credits-only is allowed
  input  wire logic                       send_valid_i,
  input  wire logic                       force_send_i,
  input  wire logic                       out_fire_i,
  input  wire credit_sync_pkg::credit_t   credits_owed_i,
  output      credit_sync_pkg::pkt_mode_e pkt_mode_o,
  output      logic                       credit_ok_o
);

  import credit_sync_pkg::*;

  // spendable credits, starts at the far-side buffer depth
  credit_t   avail_q;
  credit_t   avail_d;
  credit_t   avail_inc;
  credit_t   avail_dec;

  // cost of whatever packet is currently being offered
  credit_t   pkt_cost;

  pkt_mode_e mode_q;
  pkt_mode_e mode_d;

  logic      owes_credits;
  logic      data_affordable;
  logic      cred_only_affordable;
  logic      only_cred_only_fits;

  //////////////////////////////
  // credit gate
  //////////////////////////////

  assign owes_credits = (credits_owed_i != '0);

  // the last credit is only spent when the packet also carries credits back.
  // otherwise both sides could end up with every credit in flight and stall
  // forever, each waiting for the other
  assign data_affordable = (avail_q > DATA_PKT_COST) ||
                           ((avail_q == DATA_PKT_COST) && owes_credits);

  assign cred_only_affordable = (avail_q > CRED_ONLY_COST) ||
                                ((avail_q == CRED_ONLY_COST) && owes_credits);

  // a data packet is stuck for lack of credits, yet a credits-only packet
  // could still leave right away
  assign only_cred_only_fits = ~data_affordable & cred_only_affordable;

  always_comb begin
    if (mode_q == MODE_CREDITS_ONLY) begin
      pkt_cost    = CRED_ONLY_COST;
      credit_ok_o = cred_only_affordable;
    end else begin
      pkt_cost    = DATA_PKT_COST;
      credit_ok_o = data_affordable;
    end
  end

  //////////////////////////////
  // available counter
  //////////////////////////////

  // returned credits arrive only with the strobe
  assign avail_inc = receive_cred_i ? credits_received_i : '0;
  // credits are consumed with every accepted packet, at the current cost
  assign avail_dec = out_fire_i ? pkt_cost : '0;
  assign avail_d   = avail_q + avail_inc - avail_dec;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      avail_q <= NUM_CREDITS;
    end else begin
      avail_q <= avail_d;
    end
  end

  //////////////////////////////
  // packet mode FSM
  //////////////////////////////

  always_comb begin
    mode_d = mode_q;
    if (force_send_i && (!send_valid_i || only_cred_only_fits)) begin
      // nothing to carry the owed credits, or the data cannot be paid for,
      // so switch to sending credits on their own
      mode_d = MODE_CREDITS_ONLY;
    end else if (out_fire_i) begin
      // a packet just left and forcing is no longer needed
      mode_d = MODE_NORMAL;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mode_q <= MODE_NORMAL;
    end else begin
      mode_q <= mode_d;
    end
  end

  assign pkt_mode_o = mode_q;

endmodule

`default_nettype wire

// File: link_tx_stage.sv
`timescale 1ns/1ps
`default_nettype none

// combinational output side. Resolves the link handshake once and shares
// the result with both counters
module link_tx_stage (
  input  wire logic                       send_valid_i,
  input  wire credit_sync_pkg::data_t     data_to_send_i,
  input  wire logic                       send_ready_i,
  input  wire logic                       credit_ok_i,
  input  wire credit_sync_pkg::pkt_mode_e pkt_mode_i,
  output      logic                       send_valid_o,
  output      credit_sync_pkg::data_t     data_to_send_o,
  output      logic                       credits_only_packet_o,
  output      logic                       send_ready_o,
  output      logic                       out_fire_o,
  output      logic                       out_stall_o
);

  import credit_sync_pkg::*;

  logic cred_only;
  logic valid_out;
  logic fire;

  assign cred_only = (pkt_mode_i == MODE_CREDITS_ONLY);

  //////////////////////////////
  // outgoing packet
  //////////////////////////////

  // in credits-only mode the packet goes out without source data,
  // but the credit gate still has to agree
  assign valid_out = credit_ok_i & (send_valid_i | cred_only);

  // zeroed payload keeps the data lines quiet for credits-only packets
  assign data_to_send_o = cred_only ? '0 : data_to_send_i;

  assign credits_only_packet_o = cred_only;
  assign send_valid_o          = valid_out;

  //////////////////////////////
  // handshake
  //////////////////////////////

  assign fire = valid_out & send_ready_i;

  // accepted this cycle
  assign out_fire_o  = fire;
  // offered but held off, the owed count must not move
  assign out_stall_o = valid_out & ~send_ready_i;

  // the source only sees ready when its own word was taken.
  // a credits-only packet never consumes source data
  assign send_ready_o = cred_only ? 1'b0 : fire;

endmodule

`default_nettype wire

// File: credit_sync_top.sv
`timescale 1ns/1ps
`default_nettype none

// credit-based flow control for one serial link channel, placed on a
// valid/ready data path between a source and the link
module credit_sync_top (
  input  wire logic                     clk_i,
  input  wire logic                     reset_i,
  // source side
  input  wire logic                     send_valid_i,
  input  wire credit_sync_pkg::data_t   data_to_send_i,
  output      logic                     send_ready_o,
  // link side
  input  wire logic                     send_ready_i,
  output      logic                     send_valid_o,
  output      credit_sync_pkg::data_t   data_to_send_o,
  output      logic                     credits_only_packet_o,
  output      credit_sync_pkg::credit_t credits_to_send_o,
  // credits coming back from the far side
  input  wire logic                     receive_cred_i,
  input  wire credit_sync_pkg::credit_t credits_received_i,
  // local receive buffer output handshake
  input  wire logic                     buffer_out_valid_i,
  input  wire logic                     buffer_out_ready_i
);

  import credit_sync_pkg::*;

  // handshake pulses from the output side
  logic      out_fire;
  logic      out_stall;

  // owed credits and the force request from the input side
  credit_t   credits_owed;
  logic      force_send;

  // mode and credit gate from the controller
  pkt_mode_e pkt_mode;
  logic      credit_ok;

  //////////////////////////////
  // input side
  //////////////////////////////

  credit_return_tracker i_credit_return_tracker (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .buffer_out_valid_i (buffer_out_valid_i),
    .buffer_out_ready_i (buffer_out_ready_i),
    .out_fire_i         (out_fire),
    .out_stall_i        (out_stall),
    .credits_owed_o     (credits_owed),
    .force_send_o       (force_send)
  );

  //////////////////////////////
  // processing
  //////////////////////////////

  credit_flow_ctrl i_credit_flow_ctrl (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .credits_received_i (credits_received_i),
    .receive_cred_i     (receive_cred_i),
    .send_valid_i       (send_valid_i),
    .force_send_i       (force_send),
    .out_fire_i         (out_fire),
    .credits_owed_i     (credits_owed),
    .pkt_mode_o         (pkt_mode),
    .credit_ok_o        (credit_ok)
  );

  //////////////////////////////
  // output side
  //////////////////////////////

  link_tx_stage i_link_tx_stage (
    .send_valid_i          (send_valid_i),
    .data_to_send_i        (data_to_send_i),
    .send_ready_i          (send_ready_i),
    .credit_ok_i           (credit_ok),
    .pkt_mode_i            (pkt_mode),
    .send_valid_o          (send_valid_o),
    .data_to_send_o        (data_to_send_o),
    .credits_only_packet_o (credits_only_packet_o),
    .send_ready_o          (send_ready_o),
    .out_fire_o            (out_fire),
    .out_stall_o           (out_stall)
  );

  // the owed count rides along with every outgoing packet
  assign credits_to_send_o = credits_owed;

endmodule

`default_nettype wire

// File: credit_sync_properties.sv
`timescale 1ns/1ps
`default_nettype none

// checks one credit counter, optionally paired with a second count that shares its bound.
// the count must also not move across any cycle flagged by hold_i
module credit_sync_properties (
  input wire logic                     clk_i,
  input wire logic                     reset_i,
  input wire credit_sync_pkg::credit_t count_i,
  input wire credit_sync_pkg::credit_t extra_count_i,
  input wire logic                     hold_i
);

  import credit_sync_pkg::*;

  // one extra bit so the sum cannot wrap below the bound
  logic [CREDIT_WIDTH:0] total_count;
  int unsigned           bound_fails  = 0;
  int unsigned           stable_fails = 0;
  int unsigned           fail_count;

  assign total_count = {1'b0, count_i} + {1'b0, extra_count_i};
  assign fail_count  = bound_fails + stable_fails;

  //////////////////////////////
  // bound and stability
  //////////////////////////////

  // no more credits can exist than the far-side buffer has entries
  count_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    total_count <= {1'b0, NUM_CREDITS})
    else begin
      $error("credit count %0d exceeds the buffer depth", total_count);
      bound_fails++;
    end

  // the count offered with a waiting packet must not move under it
  count_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    hold_i |=> $stable(count_i))
    else begin
      $error("credit count changed while a packet was stalled");
      stable_fails++;
    end

endmodule

// the visible owed count stays frozen across a stall and its sum with the shadow stays bounded
bind credit_return_tracker credit_sync_properties i_owed_props (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .count_i       (owed_q),
  .extra_count_i (shadow_q),
  .hold_i        (out_stall_i)
);

// the available count only moves with a credit strobe or an accepted packet
bind credit_flow_ctrl credit_sync_properties i_avail_props (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .count_i       (avail_q),
  .extra_count_i ('0),
  .hold_i        (~receive_cred_i & ~out_fire_i)
);

`default_nettype wire

// File: tb_credit_sync.sv
`timescale 1ns/1ps
`default_nettype none

module tb_credit_sync;

  import credit_sync_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 8;
  localparam int RESET_TIMEOUT = 50;
  localparam int MAX_ROWS      = 32;

  logic    clk;
  logic    reset;
  logic    send_valid;
  data_t   send_data;
  logic    link_ready;
  logic    receive_cred;
  credit_t credits_returned;
  logic    buffer_valid;
  logic    buffer_ready;
  logic    link_valid;
  logic    source_ready;
  logic    credits_only;
  data_t   link_data;
  credit_t credits_to_send;

  // one row is one clock step with the inputs to drive and the outputs expected before the next edge
  string   row_name         [MAX_ROWS];
  logic    row_valid        [MAX_ROWS];
  data_t   row_data         [MAX_ROWS];
  logic    row_ready        [MAX_ROWS];
  logic    row_strobe       [MAX_ROWS];
  credit_t row_returned     [MAX_ROWS];
  logic    row_buf_valid    [MAX_ROWS];
  logic    row_buf_ready    [MAX_ROWS];
  logic    row_exp_valid    [MAX_ROWS];
  logic    row_exp_cred_only[MAX_ROWS];
  logic    row_exp_ready    [MAX_ROWS];
  data_t   row_exp_data     [MAX_ROWS];
  credit_t row_exp_credits  [MAX_ROWS];

  int          row_count   = 0;
  int          check_count = 0;
  int          error_count = 0;
  int          test_errors = 0;
  int unsigned assert_fails;
  integer      seed;

  credit_sync_top i_credit_sync_top (
    .clk_i                 (clk),
    .reset_i               (reset),
    .send_valid_i          (send_valid),
    .data_to_send_i        (send_data),
    .send_ready_o          (source_ready),
    .send_ready_i          (link_ready),
    .send_valid_o          (link_valid),
    .data_to_send_o        (link_data),
    .credits_only_packet_o (credits_only),
    .credits_to_send_o     (credits_to_send),
    .receive_cred_i        (receive_cred),
    .credits_received_i    (credits_returned),
    .buffer_out_valid_i    (buffer_valid),
    .buffer_out_ready_i    (buffer_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // every input starts quiet and reset is released on a rising edge
  initial begin
    reset            = 1'b1;
    send_valid       = 1'b0;
    send_data        = '0;
    link_ready       = 1'b0;
    receive_cred     = 1'b0;
    credits_returned = '0;
    buffer_valid     = 1'b0;
    buffer_ready     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_flag(input string test, input string signal,
                            input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      test_errors++;
      $display("FAILED %s %s: expected %b, actual %b", test, signal, expected, actual);
    end
  endtask

  task automatic check_data(input string test, input string signal,
                            input data_t expected, input data_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      test_errors++;
      $display("FAILED %s %s: expected %h, actual %h", test, signal, expected, actual);
    end
  endtask

  task automatic check_credit(input string test, input string signal,
                              input credit_t expected, input credit_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      test_errors++;
      $display("FAILED %s %s: expected %0d, actual %0d", test, signal, expected, actual);
    end
  endtask

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  task automatic add_row(input string name, input logic valid_in, input logic ready_in,
                         input logic strobe_in, input credit_t returned_in,
                         input logic buf_valid_in, input logic buf_ready_in,
                         input logic exp_valid_in, input logic exp_cred_only_in,
                         input logic exp_ready_in, input credit_t exp_credits_in);
    data_t payload;
    payload                      = data_t'($random(seed));
    row_name[row_count]          = name;
    row_valid[row_count]         = valid_in;
    row_data[row_count]          = payload;
    row_ready[row_count]         = ready_in;
    row_strobe[row_count]        = strobe_in;
    row_returned[row_count]      = returned_in;
    row_buf_valid[row_count]     = buf_valid_in;
    row_buf_ready[row_count]     = buf_ready_in;
    row_exp_valid[row_count]     = exp_valid_in;
    row_exp_cred_only[row_count] = exp_cred_only_in;
    row_exp_ready[row_count]     = exp_ready_in;
    // a credits-only packet carries a zero payload while a data packet passes the word through
    row_exp_data[row_count]      = exp_cred_only_in ? '0 : payload;
    row_exp_credits[row_count]   = exp_credits_in;
    row_count++;
  endtask

  // the columns are valid, ready, strobe, returned and buffer valid and ready, then the
  // expected valid, credits-only flag, source ready and credits on the link
  task automatic fill_table();
    seed = 22228;
    add_row("reset_state", 1'b0, 1'b0, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0);
    // eight credits at reset and the last one is kept back while nothing is owed
    repeat (7) begin
      add_row("deadlock_guard", 1'b1, 1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 4'd0);
    end
    add_row("deadlock_guard", 1'b1, 1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0);
    add_row("credit_return", 1'b0, 1'b1, 1'b1, 4'd3, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0);
    repeat (3) begin
      add_row("credit_return", 1'b1, 1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 4'd0);
    end
    add_row("credit_return", 1'b1, 1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0);
    // refill to five credits while two entries are released
    add_row("owed_shadow", 1'b0, 1'b0, 1'b1, 4'd4, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 4'd0);
    add_row("owed_shadow", 1'b0, 1'b0, 1'b0, 4'd0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 4'd1);
    // link stalls, so three releases pile up in the shadow
    repeat (3) begin
      add_row("owed_shadow", 1'b1, 1'b0, 1'b0, 4'd0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 4'd2);
    end
    add_row("owed_shadow", 1'b1, 1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 4'd2);
    // buffer valid without ready frees nothing
    add_row("owed_shadow", 1'b0, 1'b0, 1'b0, 4'd0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 4'd3);
    add_row("forced_cred_only", 1'b0, 1'b0, 1'b0, 4'd0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 4'd3);
    add_row("forced_cred_only", 1'b0, 1'b0, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 4'd4);
    add_row("forced_cred_only", 1'b0, 1'b0, 1'b0, 4'd0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 4'd4);
    // source data shows up as the forced packet leaves and the source is not served
    add_row("forced_cred_only", 1'b1, 1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 4'd4);
    add_row("forced_cred_only", 1'b1, 1'b0, 1'b0, 4'd0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 4'd0);
    add_row("forced_cred_only", 1'b0, 1'b0, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0);
  endtask

  task automatic run_table();
    logic last_row;
    for (int i = 0; i < row_count; i++) begin
      send_valid       <= row_valid[i];
      send_data        <= row_data[i];
      link_ready       <= row_ready[i];
      receive_cred     <= row_strobe[i];
      credits_returned <= row_returned[i];
      buffer_valid     <= row_buf_valid[i];
      buffer_ready     <= row_buf_ready[i];
      // outputs settle well before the falling edge
      @(negedge clk);
      check_flag(row_name[i], "send_valid_o", row_exp_valid[i], link_valid);
      check_flag(row_name[i], "credits_only_packet_o", row_exp_cred_only[i], credits_only);
      check_flag(row_name[i], "send_ready_o", row_exp_ready[i], source_ready);
      check_data(row_name[i], "data_to_send_o", row_exp_data[i], link_data);
      check_credit(row_name[i], "credits_to_send_o", row_exp_credits[i], credits_to_send);
      if (i == row_count - 1) begin
        last_row = 1'b1;
      end else begin
        last_row = (row_name[i] != row_name[i + 1]);
      end
      if (last_row) begin
        if (test_errors == 0) begin
          $display("test %s: ok", row_name[i]);
        end else begin
          $display("test %s: %0d errors", row_name[i], test_errors);
        end
        test_errors = 0;
      end
      @(posedge clk);
    end
  endtask

  initial begin : stimulus
    int wait_cycles;
    wait_cycles = 0;
    fill_table();
    while (reset && wait_cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (reset) begin
      $display("timeout: reset was still asserted after %0d cycles", wait_cycles);
      $display("Simulation FAILED");
    end else begin
      run_table();
      assert_fails = i_credit_sync_top.i_credit_return_tracker.i_owed_props.fail_count +
                     i_credit_sync_top.i_credit_flow_ctrl.i_avail_props.fail_count;
      if (assert_fails != 0) begin
        $display("bound assertions failed %0d times", assert_fails);
      end
      $display("%0d checks, %0d errors, %0d assertion failures",
               check_count, error_count, assert_fails);
      if (error_count == 0 && assert_fails == 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
credit_sync_pkg.sv
credit_return_tracker.sv
credit_flow_ctrl.sv
link_tx_stage.sv
credit_sync_top.sv
credit_sync_properties.sv
tb_credit_sync.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the credit sync testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_credit_sync -f project.f

# a raised error limit lets the testbench reach its own report after an assertion fires
sim_output="$(./obj_dir/Vtb_credit_sync +verilator+error+limit+100 2>&1)" || true

echo "$sim_output"

if grep -qx "Simulation PASSED" <<< "$sim_output"; then
  echo "run_sim: pass"
  exit 0
else
  echo "run_sim: fail"
  exit 1
fi
